/* source/isa_pkg.sv */
package isa_pkg;

   localparam int reg_addr_w = 5;
   localparam int data_w     = 32;

   // primary opcode field, bits 31:26
   typedef enum logic [5:0] {
      op_rtype = 6'h00,
      op_addi  = 6'h08,
      op_lw    = 6'h23,
      op_sw    = 6'h2b
   } opcode_e;

   // function field of r-type words, bits 5:0
   typedef enum logic [5:0] {
      fn_add = 6'h20,
      fn_sub = 6'h22,
      fn_and = 6'h24,
      fn_or  = 6'h25,
      fn_slt = 6'h2a
   } funct_e;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_slt,
      alu_pass_b
   } alu_op_e;

   // low 16 bits double as the immediate of i-type words
   typedef struct packed {
      logic [5:0]            opcode;
      logic [reg_addr_w-1:0] rs;
      logic [reg_addr_w-1:0] rt;
      logic [reg_addr_w-1:0] rd;
      logic [4:0]            shamt;
      logic [5:0]            funct;
   } instr_t;

endpackage

/* source/pipe_pkg.sv */
package pipe_pkg;

   localparam int imem_addr_w = 9;
   localparam int dmem_addr_w = 10;

   // external access port, instruction memory only looks at the low address bits
   typedef struct packed {
      logic [dmem_addr_w-1:0]         addr;
      logic                           wen;
      logic                           ren;
      logic [isa_pkg::data_w-1:0]     wdata;
   } mem_ext_t;

   typedef struct packed {
      isa_pkg::alu_op_e alu_op;
      logic             alu_src;
      logic             mem_read;
      logic             mem_write;
      logic             mem_to_reg;
      logic             reg_write;
   } ctrl_t;

   typedef struct packed {
      ctrl_t                          ctrl;
      logic [isa_pkg::reg_addr_w-1:0] rs;
      logic [isa_pkg::reg_addr_w-1:0] rt;
      logic [isa_pkg::reg_addr_w-1:0] dest;
      logic [isa_pkg::data_w-1:0]     rdata_1;
      logic [isa_pkg::data_w-1:0]     rdata_2;
      logic [isa_pkg::data_w-1:0]     imm;
   } id_ex_t;

   typedef struct packed {
      ctrl_t                          ctrl;
      logic [isa_pkg::reg_addr_w-1:0] dest;
      logic [isa_pkg::data_w-1:0]     alu_result;
      logic [isa_pkg::data_w-1:0]     store_data;
   } ex_mem_t;

   // writeback bus, fed back to decode and execute
   typedef struct packed {
      logic                           reg_write;
      logic [isa_pkg::reg_addr_w-1:0] dest;
      logic [isa_pkg::data_w-1:0]     wdata;
   } wb_t;

endpackage

/* source/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       enable,
   input  logic                       stall,
   input  pipe_pkg::mem_ext_t         imem_ext,
   output isa_pkg::instr_t            instr,
   output logic [isa_pkg::data_w-1:0] pc_plus_4
);

   logic [isa_pkg::data_w-1:0] pc;
   logic [isa_pkg::data_w-1:0] imem [2**pipe_pkg::imem_addr_w];
   logic                       advance;

   assign advance = enable && !stall;

   // program loading only while the pipeline is frozen
   always_ff @(posedge clk) begin
      if (!enable && imem_ext.wen) begin
         imem[imem_ext.addr[pipe_pkg::imem_addr_w-1:0]] <= imem_ext.wdata;
      end
   end

   // the read register of the instruction memory is the if/id instruction
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc        <= '0;
         instr     <= '0;
         pc_plus_4 <= '0;
      end else if (advance) begin
         instr     <= imem[pc[pipe_pkg::imem_addr_w+1:2]];
         pc_plus_4 <= pc + 32'd4;
         pc        <= pc + 32'd4;
      end
   end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           enable,
   input  isa_pkg::instr_t                instr,
   input  logic [isa_pkg::reg_addr_w-1:0] ex_dest_load,
   input  pipe_pkg::wb_t                  wb,
   output logic                           stall,
   output pipe_pkg::id_ex_t               id_ex
);

   pipe_pkg::ctrl_t                ctrl;
   logic [isa_pkg::data_w-1:0]     regs [2**isa_pkg::reg_addr_w];
   logic [isa_pkg::data_w-1:0]     rdata_1;
   logic [isa_pkg::data_w-1:0]     rdata_2;
   logic [isa_pkg::reg_addr_w-1:0] dest;
   logic                           uses_rt;

   // unknown codes leave ctrl at zero, so an all-zero word is a no-op
   always_comb begin
      ctrl = '0;
      case (instr.opcode)
         isa_pkg::op_rtype: begin
            ctrl.reg_write = 1'b1;
            case (instr.funct)
               isa_pkg::fn_add: ctrl.alu_op = isa_pkg::alu_add;
               isa_pkg::fn_sub: ctrl.alu_op = isa_pkg::alu_sub;
               isa_pkg::fn_and: ctrl.alu_op = isa_pkg::alu_and;
               isa_pkg::fn_or:  ctrl.alu_op = isa_pkg::alu_or;
               isa_pkg::fn_slt: ctrl.alu_op = isa_pkg::alu_slt;
               default:         ctrl.reg_write = 1'b0;
            endcase
         end
         isa_pkg::op_addi: begin
            ctrl.alu_src   = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         isa_pkg::op_lw: begin
            ctrl.alu_src    = 1'b1;
            ctrl.mem_read   = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.reg_write  = 1'b1;
         end
         isa_pkg::op_sw: begin
            ctrl.alu_src   = 1'b1;
            ctrl.mem_write = 1'b1;
         end
         default: ctrl = '0;
      endcase
   end

   assign uses_rt = (instr.opcode == isa_pkg::op_rtype) || (instr.opcode == isa_pkg::op_sw);
   assign dest    = (instr.opcode == isa_pkg::op_rtype) ? instr.rd : instr.rt;

   // load-use hazard against the instruction now in execute
   assign stall = (ex_dest_load != '0) &&
                  ((ex_dest_load == instr.rs) || (uses_rt && ex_dest_load == instr.rt));

   always_ff @(posedge clk) begin
      if (enable && wb.reg_write && wb.dest != '0) begin
         regs[wb.dest] <= wb.wdata;
      end
   end

   // r0 reads zero, a write in flight is seen by this read
   always_comb begin
      if (instr.rs == '0) begin
         rdata_1 = '0;
      end else if (wb.reg_write && wb.dest == instr.rs) begin
         rdata_1 = wb.wdata;
      end else begin
         rdata_1 = regs[instr.rs];
      end
      if (instr.rt == '0) begin
         rdata_2 = '0;
      end else if (wb.reg_write && wb.dest == instr.rt) begin
         rdata_2 = wb.wdata;
      end else begin
         rdata_2 = regs[instr.rt];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex <= '0;
      end else if (enable) begin
         // a stall sends a bubble down the pipe
         id_ex.ctrl    <= stall ? pipe_pkg::ctrl_t'(0) : ctrl;
         id_ex.rs      <= instr.rs;
         id_ex.rt      <= instr.rt;
         id_ex.dest    <= dest;
         id_ex.rdata_1 <= rdata_1;
         id_ex.rdata_2 <= rdata_2;
         id_ex.imm     <= {{(isa_pkg::data_w-16){instr[15]}}, instr[15:0]};
      end
   end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              enable,
   input  pipe_pkg::id_ex_t  id_ex,
   input  pipe_pkg::wb_t     wb,
   output pipe_pkg::ex_mem_t ex_mem
);

   logic [isa_pkg::data_w-1:0] op_a;
   logic [isa_pkg::data_w-1:0] rt_val;
   logic [isa_pkg::data_w-1:0] op_b;
   logic [isa_pkg::data_w-1:0] result;

   // ex/mem wins over writeback, a load in ex/mem has no data yet
   function automatic logic [isa_pkg::data_w-1:0] forward(
      input logic [isa_pkg::reg_addr_w-1:0] src,
      input logic [isa_pkg::data_w-1:0]     rdata,
      input pipe_pkg::ex_mem_t              em,
      input pipe_pkg::wb_t                  w
   );
      if (em.ctrl.reg_write && !em.ctrl.mem_read && em.dest != '0 && em.dest == src) begin
         return em.alu_result;
      end
      if (w.reg_write && w.dest != '0 && w.dest == src) begin
         return w.wdata;
      end
      return rdata;
   endfunction

   assign op_a   = forward(id_ex.rs, id_ex.rdata_1, ex_mem, wb);
   assign rt_val = forward(id_ex.rt, id_ex.rdata_2, ex_mem, wb);
   assign op_b   = id_ex.ctrl.alu_src ? id_ex.imm : rt_val;

   always_comb begin
      case (id_ex.ctrl.alu_op)
         isa_pkg::alu_add:    result = op_a + op_b;
         isa_pkg::alu_sub:    result = op_a - op_b;
         isa_pkg::alu_and:    result = op_a & op_b;
         isa_pkg::alu_or:     result = op_a | op_b;
         isa_pkg::alu_slt: begin
            result = {{(isa_pkg::data_w-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
         end
         isa_pkg::alu_pass_b: result = op_b;
         default:             result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem <= '0;
      end else if (enable) begin
         ex_mem.ctrl       <= id_ex.ctrl;
         ex_mem.dest       <= id_ex.dest;
         ex_mem.alu_result <= result;
         // store data goes out already forwarded
         ex_mem.store_data <= rt_val;
      end
   end

endmodule

/* source/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       enable,
   input  pipe_pkg::ex_mem_t          ex_mem,
   input  pipe_pkg::mem_ext_t         dmem_ext,
   output pipe_pkg::wb_t              wb,
   output logic [isa_pkg::data_w-1:0] dmem_rdata
);

   logic [isa_pkg::data_w-1:0]      dmem [2**pipe_pkg::dmem_addr_w];
   logic [pipe_pkg::dmem_addr_w-1:0] addr;
   logic [isa_pkg::data_w-1:0]      load_data;
   logic                            mw_mem_to_reg;
   logic                            mw_reg_write;
   logic [isa_pkg::reg_addr_w-1:0]  mw_dest;
   logic [isa_pkg::data_w-1:0]      mw_result;

   assign addr = ex_mem.alu_result[pipe_pkg::dmem_addr_w+1:2];

   // pipeline owns the array while enabled, the external port otherwise
   always_ff @(posedge clk) begin
      if (enable) begin
         if (ex_mem.ctrl.mem_write) begin
            dmem[addr] <= ex_mem.store_data;
         end
         if (ex_mem.ctrl.mem_read) begin
            load_data <= dmem[addr];
         end
      end else if (dmem_ext.wen) begin
         dmem[dmem_ext.addr] <= dmem_ext.wdata;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dmem_rdata    <= '0;
         mw_mem_to_reg <= 1'b0;
         mw_reg_write  <= 1'b0;
         mw_dest       <= '0;
         mw_result     <= '0;
      end else if (enable) begin
         mw_mem_to_reg <= ex_mem.ctrl.mem_to_reg;
         mw_reg_write  <= ex_mem.ctrl.reg_write;
         mw_dest       <= ex_mem.dest;
         mw_result     <= ex_mem.alu_result;
      end else if (dmem_ext.ren) begin
         dmem_rdata <= dmem[dmem_ext.addr];
      end
   end

   // load data lines up with the mem/wb register
   assign wb.reg_write = mw_reg_write;
   assign wb.dest      = mw_dest;
   assign wb.wdata     = mw_mem_to_reg ? load_data : mw_result;

endmodule

/* source/cpu.sv */
`timescale 1ns/100ps

module cpu (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       enable,
   input  pipe_pkg::mem_ext_t         imem_ext,
   input  pipe_pkg::mem_ext_t         dmem_ext,
   output logic [isa_pkg::data_w-1:0] dmem_rdata
);

   isa_pkg::instr_t                instr;
   logic                           stall;
   pipe_pkg::id_ex_t               id_ex;
   pipe_pkg::ex_mem_t              ex_mem;
   pipe_pkg::wb_t                  wb;
   logic [isa_pkg::reg_addr_w-1:0] ex_dest_load;

   // destination of a load sitting in execute, zero when there is none
   assign ex_dest_load = id_ex.ctrl.mem_read ? id_ex.dest : '0;

   fetch_stage fetch_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .stall     (stall),
      .imem_ext  (imem_ext),
      .instr     (instr),
      .pc_plus_4 ()
   );

   decode_stage decode_i (
      .clk          (clk),
      .arst_n       (arst_n),
      .enable       (enable),
      .instr        (instr),
      .ex_dest_load (ex_dest_load),
      .wb           (wb),
      .stall        (stall),
      .id_ex        (id_ex)
   );

   execute_stage execute_i (
      .clk    (clk),
      .arst_n (arst_n),
      .enable (enable),
      .id_ex  (id_ex),
      .wb     (wb),
      .ex_mem (ex_mem)
   );

   memory_stage memory_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .ex_mem     (ex_mem),
      .dmem_ext   (dmem_ext),
      .wb         (wb),
      .dmem_rdata (dmem_rdata)
   );

endmodule

/* verification/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;

   localparam int n_tests  = 11;
   localparam int prog_len = 8;
   // reset, loading, 24 run cycles, a 10 cycle pause and the read fit in 60 cycles
   localparam int cycle_limit = n_tests * 60;

   logic                       clk;
   logic                       arst_n;
   logic                       enable;
   pipe_pkg::mem_ext_t         imem_ext;
   pipe_pkg::mem_ext_t         dmem_ext;
   logic [isa_pkg::data_w-1:0] dmem_rdata;

   integer seed   = 32'h3917_5359;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;

   // test table, one row per index
   string       names    [n_tests];
   logic [31:0] progs    [n_tests][prog_len];
   logic [31:0] preloads [n_tests];
   logic [9:0]  check_at [n_tests];
   logic [31:0] expected [n_tests];
   int          pause_at [n_tests];

   cpu dut_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .imem_ext   (imem_ext),
      .dmem_ext   (dmem_ext),
      .dmem_rdata (dmem_rdata)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] rtype(input logic [5:0] fn, input int rd, input int rs,
                                         input int rt);
      return {isa_pkg::op_rtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
   endfunction

   function automatic logic [31:0] itype(input logic [5:0] op, input int rt, input int rs,
                                         input logic [15:0] imm);
      return {op, rs[4:0], rt[4:0], imm};
   endfunction

   function automatic logic [31:0] sext(input logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   task automatic build_table();
      logic [15:0] imm_a;
      logic [15:0] imm_b;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] sum;
      string       alu_names [5];
      logic [5:0]  alu_fns   [5];
      logic [31:0] alu_exp   [5];
      alu_names = '{"alu_add", "alu_sub", "alu_and", "alu_or", "alu_slt"};
      alu_fns   = '{isa_pkg::fn_add, isa_pkg::fn_sub, isa_pkg::fn_and, isa_pkg::fn_or,
                    isa_pkg::fn_slt};
      for (int t = 0; t < n_tests; t++) begin
         imm_a       = 16'($random(seed));
         imm_b       = 16'($random(seed));
         a           = sext(imm_a);
         b           = sext(imm_b);
         sum         = a + b;
         alu_exp     = '{sum, a - b, a & b, a | b, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0};
         preloads[t] = $random(seed);
         check_at[t] = '0;
         pause_at[t] = 0;
         // r1 and r2 come from addi, every program stores its result to word 0
         progs[t] = '{itype(isa_pkg::op_addi, 1, 0, imm_a), itype(isa_pkg::op_addi, 2, 0, imm_b),
                      0, 0, rtype(isa_pkg::fn_add, 3, 1, 2), rtype(isa_pkg::fn_add, 4, 3, 1),
                      0, itype(isa_pkg::op_sw, 4, 0, 16'd0)};
         case (t)
            0, 1, 2, 3, 4: begin
               names[t]    = alu_names[t];
               expected[t] = alu_exp[t];
               progs[t][4] = rtype(alu_fns[t], 3, 1, 2);
               progs[t][5] = '0;
               progs[t][7] = itype(isa_pkg::op_sw, 3, 0, 16'd0);
            end
            5: begin
               names[t]    = "fwd_dist1";
               expected[t] = sum + a;
            end
            6: begin
               names[t]    = "fwd_dist2";
               expected[t] = sum + b;
               progs[t][5] = '0;
               progs[t][6] = rtype(isa_pkg::fn_add, 4, 3, 2);
            end
            7: begin
               names[t]    = "fwd_dist3";
               expected[t] = sum;
               progs[t]    = '{itype(isa_pkg::op_addi, 1, 0, imm_a), 0, 0,
                               itype(isa_pkg::op_addi, 2, 1, imm_b), 0, 0,
                               itype(isa_pkg::op_sw, 2, 0, 16'd0), 0};
            end
            8: begin
               names[t]    = "load_use";
               expected[t] = preloads[t] + b;
               progs[t]    = '{itype(isa_pkg::op_addi, 2, 0, imm_b), 0, 0,
                               itype(isa_pkg::op_lw, 1, 0, 16'd0),
                               rtype(isa_pkg::fn_add, 3, 1, 2), 0, 0,
                               itype(isa_pkg::op_sw, 3, 0, 16'd0)};
            end
            9: begin
               names[t]    = "r0_write";
               expected[t] = '0;
               progs[t]    = '{itype(isa_pkg::op_addi, 0, 0, imm_a),
                               itype(isa_pkg::op_sw, 0, 0, 16'd0), 0, 0, 0, 0, 0, 0};
            end
            default: begin
               names[t]    = "enable_pause";
               expected[t] = sum + a;
               pause_at[t] = 5;
            end
         endcase
      end
   endtask

   task automatic reset_cpu();
      @(negedge clk);
      arst_n = 1'b0;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic write_word(input bit to_dmem, input int addr, input logic [31:0] data);
      pipe_pkg::mem_ext_t w;
      w       = '0;
      w.addr  = addr[9:0];
      w.wen   = 1'b1;
      w.wdata = data;
      @(negedge clk);
      if (to_dmem) begin
         dmem_ext = w;
      end else begin
         imem_ext = w;
      end
   endtask

   task automatic ports_idle();
      @(negedge clk);
      imem_ext = '0;
      dmem_ext = '0;
   endtask

   // 24 enabled cycles, with an optional 10 cycle freeze after cycle pause
   task automatic run_program(input int pause);
      @(negedge clk);
      enable = 1'b1;
      for (int c = 1; c <= 24; c++) begin
         @(negedge clk);
         if (c == pause) begin
            enable = 1'b0;
            repeat (10) @(negedge clk);
            enable = 1'b1;
         end
      end
      enable = 1'b0;
   endtask

   task automatic read_word(input logic [9:0] addr);
      @(negedge clk);
      dmem_ext.addr = addr;
      dmem_ext.ren  = 1'b1;
      @(negedge clk);
      dmem_ext.ren  = 1'b0;
   endtask

   initial begin
      clk      = 1'b0;
      arst_n   = 1'b0;
      enable   = 1'b0;
      imem_ext = '0;
      dmem_ext = '0;
      build_table();
      // words past the programs stay no-ops for every run
      for (int i = prog_len; i < 32; i++) begin
         write_word(1'b0, i, '0);
      end
      ports_idle();
      for (int t = 0; t < n_tests; t++) begin
         reset_cpu();
         for (int i = 0; i < prog_len; i++) begin
            write_word(1'b0, i, progs[t][i]);
         end
         write_word(1'b1, 0, preloads[t]);
         ports_idle();
         run_program(pause_at[t]);
         read_word(check_at[t]);
         checks++;
         assert (dmem_rdata == expected[t]) else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", names[t], expected[t], dmem_rdata);
         end
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* cpu.f */
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu.sv
verification/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -o cpu_sim

output=$(./obj_dir/cpu_sim)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
   exit 0
else
   exit 1
fi
